//--- rtl/ptw_cfg.svh
//==================================================
// PTW miss queue configuration
//==================================================
`ifndef PTW_CFG_SVH
`define PTW_CFG_SVH

// pending walks held in the miss queue
`define PTW_MISSQ_SIZE 8

// address, address-space id and ROB tag widths
`define PTW_ADDR_W 32
`define PTW_ASID_W 8
`define PTW_ID_W 6

// 8 KiB pages
`define PTW_PAGE_SHIFT 13

// level 0 index is vaddr[23:13], level 1 index is vaddr[31:24]
`define PTW_L0_MSB 23
`define PTW_L1_LSB 24

// 4-byte PTEs
`define PTW_PTE_SHIFT 2

// miss and fill buffers
`define PTW_FIFO_DEPTH 4

`endif

//--- rtl/ptw_pkg.sv
//==================================================
// PTW shared types
//==================================================
`include "ptw_cfg.svh"

package ptw_pkg;

	typedef logic [`PTW_ADDR_W-1:0] vaddr_t;
	typedef logic [`PTW_ADDR_W-1:0] paddr_t;
	typedef logic [`PTW_ASID_W-1:0] asid_t;
	typedef logic [`PTW_ID_W-1:0] rob_id_t;
	typedef logic [$clog2(`PTW_MISSQ_SIZE)-1:0] qidx_t;

	// page number, virtual or physical
	typedef logic [`PTW_ADDR_W-`PTW_PAGE_SHIFT-1:0] page_t;

	// miss request from the TLB
	typedef struct packed {
		asid_t asid;
		vaddr_t vaddr;
		rob_id_t id;
	} tlb_miss_t;

	// 4-byte page table entry
	typedef struct packed {
		page_t ppn;
		logic [`PTW_PAGE_SHIFT-3:0] rsv;
		logic s;
		logic v;
	} pte_t;

	// one pending walk
	typedef struct packed {
		logic valid;
		logic busy;
		logic lvl;
		asid_t asid;
		vaddr_t vaddr;
		rob_id_t id;
		paddr_t tadr;
	} miss_entry_t;

	// finished walk returned to the TLB
	typedef struct packed {
		asid_t asid;
		page_t vpage;
		page_t ppage;
		rob_id_t id;
		logic fault;
	} tlb_fill_t;

endpackage

//--- rtl/sync_fifo.sv
//==================================================
// Valid/ready synchronous FIFO
//==================================================
`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst,
	input payload_t in_data,
	input logic in_valid,
	output logic in_ready,
	output payload_t out_data,
	output logic out_valid,
	input logic out_ready,
	output logic full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0] count;
	logic live;
	logic push;
	logic pop;

	// ready stays low until the first cycle out of reset
	assign full = (count == (PTR_W+1)'(DEPTH));
	assign in_ready = live && !full;
	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			live <= 1'b0;
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			live <= 1'b1;
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			count <= count + push - pop;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	// a full or an empty buffer has its pointers together
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		full |-> wr_ptr == rd_ptr);

	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		!out_valid |-> wr_ptr == rd_ptr);

endmodule

//--- rtl/pte_fetch.sv
//==================================================
// APB page table entry fetch
//==================================================
`timescale 1ns/1ps

module pte_fetch (
	input logic clk,
	input logic rst,
	input logic req,
	input ptw_pkg::paddr_t req_adr,
	output logic busy,
	output logic done,
	output ptw_pkg::pte_t pte,
	output logic err,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output ptw_pkg::paddr_t paddr,
	input logic [$bits(ptw_pkg::pte_t)-1:0] prdata,
	input logic pready,
	input logic pslverr
);

	import ptw_pkg::*;

	typedef enum logic [1:0] {IDLE, SETUP, ACCESS} state_t;

	state_t state;

	// read only master
	assign pwrite = 1'b0;
	assign psel = (state != IDLE);
	assign penable = (state == ACCESS);
	assign busy = (state != IDLE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: if (req) state <= SETUP;
				SETUP: state <= ACCESS;
				ACCESS: begin
					if (pready) begin
						state <= IDLE;
						done <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// address taken with the request, data held until the next transfer
	always_ff @(posedge clk) begin
		if (state == IDLE && req)
			paddr <= req_adr;
		if (state == ACCESS && pready) begin
			pte <= pte_t'(prdata);
			err <= pslverr;
		end
	end

	// a request while a transfer runs would be lost
	a_req_idle: assert property (@(posedge clk) disable iff (rst)
		req |-> !busy);

endmodule

//--- rtl/miss_queue.sv
//==================================================
// Page-table walker miss queue
//==================================================
`timescale 1ns/1ps
`include "ptw_cfg.svh"

module miss_queue (
	input logic clk,
	input logic rst,
	input ptw_pkg::paddr_t root_base,
	input ptw_pkg::tlb_miss_t miss,
	input logic miss_valid,
	output logic miss_pop,
	output logic dup_flag,
	output logic fetch_req,
	output ptw_pkg::paddr_t fetch_adr,
	input logic fetch_busy,
	input logic fetch_done,
	input ptw_pkg::pte_t fetch_pte,
	input logic fetch_err,
	output ptw_pkg::tlb_fill_t fill,
	output logic fill_push,
	input logic fill_full
);

	import ptw_pkg::*;

	localparam int VA_MSB = `PTW_ADDR_W - 1;
	localparam int PS = `PTW_PAGE_SHIFT;
	localparam int L1_W = `PTW_ADDR_W - `PTW_L1_LSB;
	localparam int PPN_W = $bits(page_t);

	miss_entry_t q [`PTW_MISSQ_SIZE];

	logic dup_hit;
	logic free_found;
	qidx_t free_idx;
	logic sel_found;
	qidx_t sel_idx;
	logic alloc;
	logic start;

	// walk in flight, from fetch_req until its entry is updated
	logic inflight;
	qidx_t cur_idx;
	logic done_q;
	miss_entry_t cur;

	logic fault;
	logic leaf;
	logic finish;
	page_t leaf_page;
	paddr_t root_tadr;
	paddr_t next_tadr;

	//==================================================
	// search: duplicate, free slot, next walk
	//==================================================
	always_comb begin
		dup_hit = 1'b0;
		free_found = 1'b0;
		free_idx = '0;
		sel_found = 1'b0;
		sel_idx = '0;
		for (int i = 0; i < `PTW_MISSQ_SIZE; i++) begin
			if (q[i].valid && q[i].asid == miss.asid &&
				q[i].vaddr[VA_MSB:PS] == miss.vaddr[VA_MSB:PS])
				dup_hit = 1'b1;
			if (!q[i].valid && !free_found) begin
				free_found = 1'b1;
				free_idx = qidx_t'(i);
			end
			// lowest index wins
			if (q[i].valid && !q[i].busy && !sel_found) begin
				sel_found = 1'b1;
				sel_idx = qidx_t'(i);
			end
		end
	end

	assign miss_pop = miss_valid && free_found;
	assign alloc = miss_pop && !dup_hit;

	// level 1 table slot for the incoming miss
	assign root_tadr = root_base +
		paddr_t'({miss.vaddr[VA_MSB:`PTW_L1_LSB], {`PTW_PTE_SHIFT{1'b0}}});

	// one fetch at a time, and never when the fill FIFO could overflow
	assign start = sel_found && !fetch_busy && !inflight && !fill_full;
	assign fetch_req = start;
	assign fetch_adr = q[sel_idx].tadr;

	//==================================================
	// walk rules on the returned PTE
	//==================================================
	assign cur = q[cur_idx];

	assign fault = fetch_err || !fetch_pte.v || (!cur.lvl && !fetch_pte.s);
	assign leaf = !fault && fetch_pte.s;
	assign finish = done_q && (fault || leaf);

	// superpage keeps the level 0 index from the virtual address
	assign leaf_page = cur.lvl ?
		{fetch_pte.ppn[PPN_W-1 -: L1_W], cur.vaddr[`PTW_L0_MSB:PS]} : fetch_pte.ppn;

	assign next_tadr = {fetch_pte.ppn, {PS{1'b0}}} +
		paddr_t'({cur.vaddr[`PTW_L0_MSB:PS], {`PTW_PTE_SHIFT{1'b0}}});

	assign fill_push = finish;
	assign fill.asid = cur.asid;
	assign fill.vpage = cur.vaddr[VA_MSB:PS];
	assign fill.ppage = fault ? '0 : leaf_page;
	assign fill.id = cur.id;
	assign fill.fault = fault;

	//==================================================
	// entry state
	//==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `PTW_MISSQ_SIZE; i++) begin
				q[i].valid <= 1'b0;
				q[i].busy <= 1'b0;
			end
			inflight <= 1'b0;
			cur_idx <= '0;
			done_q <= 1'b0;
			dup_flag <= 1'b0;
		end else begin
			done_q <= fetch_done;
			dup_flag <= miss_pop && dup_hit;

			if (alloc) begin
				q[free_idx].valid <= 1'b1;
				q[free_idx].busy <= 1'b0;
				q[free_idx].lvl <= 1'b1;
				q[free_idx].asid <= miss.asid;
				q[free_idx].vaddr <= miss.vaddr;
				q[free_idx].id <= miss.id;
				q[free_idx].tadr <= root_tadr;
			end

			if (start) begin
				q[sel_idx].busy <= 1'b1;
				cur_idx <= sel_idx;
				inflight <= 1'b1;
			end

			// retire into the fill FIFO or step down to level 0
			if (done_q) begin
				inflight <= 1'b0;
				q[cur_idx].busy <= 1'b0;
				if (finish) begin
					q[cur_idx].valid <= 1'b0;
				end else begin
					q[cur_idx].lvl <= 1'b0;
					q[cur_idx].tadr <= next_tadr;
				end
			end
		end
	end

	// a finished walk always finds room in the fill FIFO
	a_fill_room: assert property (@(posedge clk) disable iff (rst)
		fill_push |-> !fill_full);

	a_done_busy: assert property (@(posedge clk) disable iff (rst)
		fetch_done |-> inflight && q[cur_idx].valid && q[cur_idx].busy);

endmodule

//--- rtl/ptw_top.sv
//==================================================
// Page-table walker top level
//==================================================
`timescale 1ns/1ps
`include "ptw_cfg.svh"

module ptw_top (
	input logic clk,
	input logic rst,
	input ptw_pkg::tlb_miss_t miss_in,
	input logic miss_valid,
	output logic miss_ready,
	input ptw_pkg::paddr_t root_base,
	output logic dup_flag,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output ptw_pkg::paddr_t paddr,
	input logic [$bits(ptw_pkg::pte_t)-1:0] prdata,
	input logic pready,
	input logic pslverr,
	output ptw_pkg::tlb_fill_t fill_out,
	output logic fill_valid,
	input logic fill_ready
);

	import ptw_pkg::*;

	tlb_miss_t miss_head;
	logic head_valid;
	logic miss_pop;
	logic fetch_req;
	paddr_t fetch_adr;
	logic fetch_busy;
	logic fetch_done;
	pte_t fetch_pte;
	logic fetch_err;
	tlb_fill_t fill;
	logic fill_push;
	logic fill_full;

	// incoming TLB misses
	sync_fifo #(
		.payload_t(tlb_miss_t),
		.DEPTH(`PTW_FIFO_DEPTH)
	) u_miss_fifo (
		.clk(clk),
		.rst(rst),
		.in_data(miss_in),
		.in_valid(miss_valid),
		.in_ready(miss_ready),
		.out_data(miss_head),
		.out_valid(head_valid),
		.out_ready(miss_pop),
		.full()
	);

	miss_queue u_miss_queue (
		.clk(clk),
		.rst(rst),
		.root_base(root_base),
		.miss(miss_head),
		.miss_valid(head_valid),
		.miss_pop(miss_pop),
		.dup_flag(dup_flag),
		.fetch_req(fetch_req),
		.fetch_adr(fetch_adr),
		.fetch_busy(fetch_busy),
		.fetch_done(fetch_done),
		.fetch_pte(fetch_pte),
		.fetch_err(fetch_err),
		.fill(fill),
		.fill_push(fill_push),
		.fill_full(fill_full)
	);

	pte_fetch u_pte_fetch (
		.clk(clk),
		.rst(rst),
		.req(fetch_req),
		.req_adr(fetch_adr),
		.busy(fetch_busy),
		.done(fetch_done),
		.pte(fetch_pte),
		.err(fetch_err),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	// finished walks, full stalls new fetches upstream
	sync_fifo #(
		.payload_t(tlb_fill_t),
		.DEPTH(`PTW_FIFO_DEPTH)
	) u_fill_fifo (
		.clk(clk),
		.rst(rst),
		.in_data(fill),
		.in_valid(fill_push),
		.in_ready(),
		.out_data(fill_out),
		.out_valid(fill_valid),
		.out_ready(fill_ready),
		.full(fill_full)
	);

endmodule

//--- dv/apb_page_mem.sv
//==================================================
// APB page table memory model
//==================================================
`timescale 1ns/1ps

module apb_page_mem (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input ptw_pkg::paddr_t paddr,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);

	import ptw_pkg::*;

	// four 8 KiB pages, page 0 holds the root table
	localparam int WORDS = 8192;

	pte_t pte_mem [WORDS];
	logic err_mem [WORDS];
	logic [1:0] wait_cnt;
	logic [12:0] widx;

	assign widx = paddr[14:2];
	assign pready = penable && (wait_cnt == 2'd0);
	assign prdata = pte_mem[widx];
	// the tables are read only, so a write is refused
	assign pslverr = pready && (pwrite || err_mem[widx]);

	// 0 to 3 wait states, picked in the setup cycle
	always @(posedge clk) begin
		if (rst)
			wait_cnt <= 2'd0;
		else if (psel && !penable)
			wait_cnt <= 2'($urandom % 4);
		else if (penable && wait_cnt != 2'd0)
			wait_cnt <= wait_cnt - 2'd1;
	end

	// random mix of invalid, table pointer and leaf entries
	task automatic build_tables();
		int kind;
		pte_t p;
		for (int i = 0; i < WORDS; i++) begin
			kind = $urandom % 16;
			p = pte_t'($urandom);
			p.v = (kind >= 2);
			p.s = (kind >= 9);
			// table pointers land on pages 1 to 3
			if (kind >= 2 && kind < 9)
				p.ppn = page_t'(1 + $urandom % 3);
			pte_mem[i] = p;
			err_mem[i] = ($urandom % 16 == 0);
		end
	endtask

endmodule

//--- dv/tb_ptw.sv
//==================================================
// PTW miss queue testbench
//==================================================
`timescale 1ns/1ps
`include "ptw_cfg.svh"

module tb_ptw;

	import ptw_pkg::*;

	localparam int N_RANDOM = 40;
	localparam int N_DUP = 40;
	localparam int N_FULL = `PTW_MISSQ_SIZE + 2 * `PTW_FIFO_DEPTH;
	localparam int N_STALL = 40;
	localparam int MISS_TOTAL = N_RANDOM + N_DUP + N_FULL + N_STALL;
	localparam int WATCHDOG_CYCLES = MISS_TOTAL * 40 + 200;
	localparam paddr_t ROOT = '0;

	logic clk;
	logic rst;
	tlb_miss_t miss_in;
	logic miss_valid;
	logic miss_ready;
	logic dup_flag;
	logic psel;
	logic penable;
	logic pwrite;
	paddr_t paddr;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	tlb_fill_t fill_out;
	logic fill_valid;
	logic fill_ready;

	// per test bookkeeping, indexed by miss id
	tlb_miss_t sent [64];
	int accept_cycle [64];
	int fill_cycle [64];
	bit filled [64];
	bit dup_marked [64];
	int accepted;
	int fills_seen;
	int dups_seen;
	int cycle;
	int errors;
	int err_at_start;
	int tests_run;
	int tests_failed;
	bit sending;

	ptw_top uut (
		.clk(clk),
		.rst(rst),
		.miss_in(miss_in),
		.miss_valid(miss_valid),
		.miss_ready(miss_ready),
		.root_base(ROOT),
		.dup_flag(dup_flag),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.fill_out(fill_out),
		.fill_valid(fill_valid),
		.fill_ready(fill_ready)
	);

	apb_page_mem page_mem (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial cycle = 0;
	always @(posedge clk) cycle++;

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("ERROR at %0t: watchdog expired after %0d cycles, the walks never finished",
			$time, WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	//==================================================
	// reference walker
	//==================================================
	function automatic paddr_t l1_adr(tlb_miss_t m);
		return ROOT + {22'd0, m.vaddr[31:24], 2'b00};
	endfunction

	// level 1 entry points to a level 0 table
	function automatic bit has_l0(tlb_miss_t m);
		paddr_t a1;
		pte_t p1;
		a1 = l1_adr(m);
		p1 = page_mem.pte_mem[a1[14:2]];
		return !page_mem.err_mem[a1[14:2]] && p1.v && !p1.s;
	endfunction

	function automatic paddr_t l0_adr(tlb_miss_t m);
		paddr_t a1;
		pte_t p1;
		a1 = l1_adr(m);
		p1 = page_mem.pte_mem[a1[14:2]];
		return {p1.ppn, 13'd0} + {19'd0, m.vaddr[23:13], 2'b00};
	endfunction

	function automatic tlb_fill_t ref_walk(tlb_miss_t m);
		tlb_fill_t f;
		paddr_t a1;
		paddr_t a0;
		pte_t p1;
		pte_t p0;
		f.asid = m.asid;
		f.vpage = m.vaddr[31:13];
		f.id = m.id;
		f.ppage = '0;
		f.fault = 1'b1;
		a1 = l1_adr(m);
		p1 = page_mem.pte_mem[a1[14:2]];
		if (page_mem.err_mem[a1[14:2]] || !p1.v)
			return f;
		f.fault = 1'b0;
		if (p1.s) begin
			// superpage
			f.ppage = {p1.ppn[18:11], m.vaddr[23:13]};
			return f;
		end
		a0 = l0_adr(m);
		p0 = page_mem.pte_mem[a0[14:2]];
		f.fault = page_mem.err_mem[a0[14:2]] || !p0.v || !p0.s;
		f.ppage = p0.ppn;
		return f;
	endfunction

	function automatic bit same_key(tlb_miss_t a, tlb_miss_t b);
		return a.asid == b.asid && a.vaddr[31:13] == b.vaddr[31:13];
	endfunction

	//==================================================
	// compare tasks
	//==================================================
	task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
		errors++;
		$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
	endtask

	task automatic report_text(string what);
		errors++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp)
			report_value(name, 32'(got), 32'(exp));
	endtask

	task automatic check_fill(tlb_fill_t got, tlb_fill_t exp);
		if (got.asid !== exp.asid)
			report_value("fill_out.asid", 32'(got.asid), 32'(exp.asid));
		if (got.vpage !== exp.vpage)
			report_value("fill_out.vpage", 32'(got.vpage), 32'(exp.vpage));
		if (got.fault !== exp.fault)
			report_value("fill_out.fault", 32'(got.fault), 32'(exp.fault));
		else if (!exp.fault && got.ppage !== exp.ppage)
			report_value("fill_out.ppage", 32'(got.ppage), 32'(exp.ppage));
	endtask

	// each flag claims one unclaimed pending miss with an older unclaimed pending twin
	task automatic check_dup();
		bit found;
		found = 1'b0;
		for (int d = 0; d < accepted && !found; d++)
			for (int e = 0; e < d; e++)
				if (!found && !filled[d] && !filled[e] && !dup_marked[d] &&
					!dup_marked[e] && same_key(sent[d], sent[e])) begin
					found = 1'b1;
					dup_marked[d] = 1'b1;
				end
		if (!found)
			report_text("dup_flag raised with no pending miss of the same ASID and page");
	endtask

	task automatic check_apb(paddr_t got);
		bit found;
		found = 1'b0;
		for (int i = 0; i < accepted; i++) begin
			if (!filled[i] && got == l1_adr(sent[i]))
				found = 1'b1;
			if (!filled[i] && has_l0(sent[i]) && got == l0_adr(sent[i]))
				found = 1'b1;
		end
		if (!found) begin
			errors++;
			$display("ERROR %0t paddr got %h expected a table address of a pending walk",
				$time, got);
		end
	endtask

	task automatic take_fill(tlb_fill_t got);
		int id;
		id = int'(got.id);
		if (id >= accepted || filled[id]) begin
			report_text("fill arrived for an id with no waiting miss (repeated fill)");
		end else begin
			check_fill(got, ref_walk(sent[id]));
			filled[id] = 1'b1;
			fill_cycle[id] = cycle;
			fills_seen++;
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			if (dup_flag) begin
				check_dup();
				dups_seen++;
			end
			if (psel) begin
				check_bit("pwrite", pwrite, 1'b0);
				if (!penable)
					check_apb(paddr);
			end
			if (fill_valid && fill_ready)
				take_fill(fill_out);
		end
	end

	//==================================================
	// stimulus
	//==================================================
	task automatic idle_cycles(int n);
		repeat (n) begin
			@(posedge clk);
			#10;
		end
	endtask

	task automatic send_miss(tlb_miss_t m, int max_wait, output bit ok);
		int waited;
		waited = 0;
		ok = 1'b0;
		miss_in = m;
		miss_valid = 1'b1;
		@(negedge clk);
		while (!miss_ready && waited < max_wait) begin
			@(negedge clk);
			waited++;
		end
		if (miss_ready) begin
			ok = 1'b1;
			sent[accepted] = m;
			accept_cycle[accepted] = cycle;
			accepted++;
		end
		@(posedge clk);
		#10;
		miss_valid = 1'b0;
	endtask

	function automatic tlb_miss_t rand_miss(int asids, int l1s, int pages);
		tlb_miss_t m;
		m.asid = asid_t'($urandom % asids);
		m.vaddr = {8'($urandom % l1s), 11'($urandom % pages), 13'($urandom)};
		m.id = rob_id_t'(accepted);
		return m;
	endfunction

	function automatic tlb_miss_t distinct_miss(int i);
		tlb_miss_t m;
		m.asid = 8'd3;
		m.vaddr = {8'(i % 8), 11'(64 + i / 8), 13'd0};
		m.id = rob_id_t'(accepted);
		return m;
	endfunction

	task automatic start_test();
		accepted = 0;
		fills_seen = 0;
		dups_seen = 0;
		for (int i = 0; i < 64; i++) begin
			filled[i] = 1'b0;
			dup_marked[i] = 1'b0;
		end
		err_at_start = errors;
	endtask

	// every miss ends as one fill or one duplicate
	task automatic drain_and_check();
		bit twin;
		while (fills_seen + dups_seen < accepted)
			@(negedge clk);
		repeat (4) @(negedge clk);
		if (fills_seen + dups_seen != accepted)
			report_text("fills plus duplicates differ from the number of accepted misses");
		for (int d = 0; d < accepted; d++) begin
			twin = 1'b0;
			for (int e = 0; e < d; e++)
				if (filled[e] && same_key(sent[e], sent[d]) && fill_cycle[e] > accept_cycle[d])
					twin = 1'b1;
			if (!filled[d] && !twin)
				report_text("a miss got no fill and had no pending twin");
		end
		@(posedge clk);
		#10;
	endtask

	task automatic end_test(string name);
		tests_run++;
		if (errors != err_at_start) begin
			tests_failed++;
			$display("test %s: FAIL, %0d errors", name, errors - err_at_start);
		end else begin
			$display("test %s: pass, %0d misses, %0d duplicates", name, accepted, dups_seen);
		end
	endtask

	initial begin
		bit ok;
		void'($urandom(37623));
		rst = 1'b1;
		miss_in = '0;
		miss_valid = 1'b0;
		fill_ready = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		sending = 1'b0;
		start_test();
		page_mem.build_tables();

		repeat (2) @(posedge clk);
		@(negedge clk);
		check_bit("miss_ready", miss_ready, 1'b0);
		check_bit("fill_valid", fill_valid, 1'b0);
		check_bit("dup_flag", dup_flag, 1'b0);
		check_bit("psel", psel, 1'b0);
		check_bit("penable", penable, 1'b0);
		@(posedge clk);
		#10;
		rst = 1'b0;
		@(negedge clk);
		check_bit("fill_valid", fill_valid, 1'b0);
		check_bit("dup_flag", dup_flag, 1'b0);
		check_bit("psel", psel, 1'b0);
		check_bit("penable", penable, 1'b0);
		@(posedge clk);
		#10;
		end_test("reset_values");

		start_test();
		fill_ready = 1'b1;
		for (int i = 0; i < N_RANDOM; i++) begin
			send_miss(rand_miss(4, 8, 16), 1000, ok);
			idle_cycles($urandom % 3);
		end
		drain_and_check();
		end_test("random_walks");

		// few keys, back to back, so twins overlap
		start_test();
		for (int i = 0; i < N_DUP; i++)
			send_miss(rand_miss(1, 2, 2), 1000, ok);
		drain_and_check();
		end_test("duplicates");

		// fill FIFO, queue and miss FIFO all fill up
		start_test();
		fill_ready = 1'b0;
		for (int i = 0; i < N_FULL; i++) begin
			send_miss(distinct_miss(i), 200, ok);
			if (!ok)
				report_text("miss refused before the queue and both FIFOs were full");
		end
		send_miss(distinct_miss(N_FULL), 200, ok);
		if (ok)
			report_text("miss_ready stayed high with the queue and both FIFOs full");
		fill_ready = 1'b1;
		drain_and_check();
		end_test("full_queue");

		start_test();
		sending = 1'b1;
		fork
			begin
				for (int i = 0; i < N_STALL; i++) begin
					send_miss(rand_miss(4, 8, 16), 1000, ok);
					idle_cycles($urandom % 2);
				end
				sending = 1'b0;
			end
			begin
				while (sending) begin
					fill_ready = 1'($urandom % 2);
					idle_cycles($urandom % 8 + 1);
				end
				fill_ready = 1'b1;
			end
		join
		drain_and_check();
		end_test("fill_backpressure");

		$display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- files.f
+incdir+rtl
rtl/ptw_pkg.sv
rtl/sync_fifo.sv
rtl/pte_fetch.sv
rtl/miss_queue.sv
rtl/ptw_top.sv
dv/apb_page_mem.sv
dv/tb_ptw.sv

//--- Makefile
VERILATOR := verilator
TOP := tb_ptw
RTL_TOP := ptw_top
FILELIST := files.f
SIM_FLAGS := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR := obj_dir
LOG := sim.log
PASS_MSG := Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the log holds the pass line
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qxF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
